// ==== hw/kv_defines_pkg.sv ====
package kv_defines_pkg;

    // vault geometry
    localparam int KV_NUM_ENTRIES = 8;
    localparam int KV_ENTRY_ADDR_W = 3;
    localparam int KV_ENTRY_DWORDS = 16;
    localparam int KV_ENTRY_SIZE_W = 4;
    localparam int KV_NUM_DEST = 6;

    // widest client result, one full entry
    localparam int KV_DATA_WIDTH = KV_ENTRY_DWORDS * 32;

    // client ids
    localparam int KV_CLIENT_ID_W = 3;

    // entries below this index belong to the owner client only
    localparam logic [KV_ENTRY_ADDR_W-1:0] KV_RSVD_ENTRIES = 3'd2;
    localparam logic [KV_CLIENT_ID_W-1:0] KV_OWNER_ID = 3'd0;

    // dword offset inside one entry
    typedef logic [KV_ENTRY_SIZE_W-1:0] kv_offset_t;

    // client control register
    typedef struct packed {
        logic write_en;
        logic [KV_ENTRY_ADDR_W-1:0] write_entry;
        // destinations that may later consume this key
        logic [KV_NUM_DEST-1:0] write_dest_vld;
    } kv_write_ctrl_reg_t;

    // fields the access rules look at
    typedef struct packed {
        logic [KV_CLIENT_ID_W-1:0] client_id;
        logic [KV_ENTRY_ADDR_W-1:0] write_entry;
        logic debug_locked;
    } kv_write_filter_metrics_t;

    // outcome of the last write
    typedef enum logic [7:0] {
        KV_SUCCESS = 8'h00,
        KV_WRITE_FAIL = 8'h01
    } kv_error_code_e;

endpackage

// ==== hw/kv_write_if.sv ====
`timescale 1ns/1ns

interface kv_write_if;

    // one dword lands per cycle with write_en high
    logic write_en;
    logic [kv_defines_pkg::KV_ENTRY_ADDR_W-1:0] write_entry;
    kv_defines_pkg::kv_offset_t write_offset;
    logic [31:0] write_data;
    // zero until the final dword of a write
    logic [kv_defines_pkg::KV_NUM_DEST-1:0] write_dest_valid;
    // same-cycle reject from the vault, entry is locked
    logic error;

    modport client (
        output write_en,
        output write_entry,
        output write_offset,
        output write_data,
        output write_dest_valid,
        input error
    );

    modport vault (
        input write_en,
        input write_entry,
        input write_offset,
        input write_data,
        input write_dest_valid,
        output error
    );

endinterface

// ==== hw/kv_write_rule_check.sv ====
`timescale 1ns/1ns

module kv_write_rule_check (
    input logic clk,
    input logic rst_b,
    input kv_defines_pkg::kv_write_filter_metrics_t write_metrics,
    output logic write_allow
);

    kv_defines_pkg::kv_write_filter_metrics_t metrics_q;
    logic rsvd_target;
    logic owner_client;

    // metrics settle one cycle ahead of the start strobe,
    // so the flopped copy is valid when the strobe arrives
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            // come out of reset locked so nothing is allowed yet
            metrics_q <= '{client_id: '0, write_entry: '0, debug_locked: 1'b1};
        end else begin
            metrics_q <= write_metrics;
        end
    end

    // reserved entries sit at the bottom of the vault
    assign rsvd_target = metrics_q.write_entry < kv_defines_pkg::KV_RSVD_ENTRIES;
    assign owner_client = metrics_q.client_id == kv_defines_pkg::KV_OWNER_ID;

    // allow depends only on flopped state
    // debug lock blocks every write
    assign write_allow = !metrics_q.debug_locked && (!rsvd_target || owner_client);

    // an X on the metrics would turn into a bogus allow one cycle later
    metrics_known_a: assert property (
        @(posedge clk) disable iff (!rst_b) !$isunknown(write_metrics)
    );

endmodule

// ==== hw/kv_fsm.sv ====
`timescale 1ns/1ns

module kv_fsm #(
    parameter int DATA_WIDTH = 512,
    localparam int OFFSET_W = $clog2(DATA_WIDTH / 32)
) (
    input logic clk,
    input logic rst_b,
    input logic zeroize,
    input logic start,
    input logic allow,
    input logic [OFFSET_W:0] num_dwords,
    output logic [OFFSET_W-1:0] read_offset,
    output logic write_en,
    output logic [OFFSET_W-1:0] write_offset,
    output logic write_last,
    output logic ready,
    output logic done
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_DONE
    } state_e;

    state_e state_q;
    logic [OFFSET_W-1:0] cnt_q;
    logic [OFFSET_W:0] last_idx;
    logic at_last;

    // index of the final dword, num_dwords is held for the whole write
    assign last_idx = num_dwords - 1'b1;
    assign at_last = {1'b0, cnt_q} == last_idx;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state_q <= ST_IDLE;
            cnt_q <= '0;
        end else if (zeroize) begin
            // abandon any write in flight
            state_q <= ST_IDLE;
            cnt_q <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    cnt_q <= '0;
                    if (start) begin
                        // denied or empty write skips straight to done
                        if (allow && (num_dwords != '0)) begin
                            state_q <= ST_WRITE;
                        end else begin
                            state_q <= ST_DONE;
                        end
                    end
                end
                ST_WRITE: begin
                    if (at_last) begin
                        state_q <= ST_DONE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                ST_DONE: begin
                    // single cycle done pulse
                    state_q <= ST_IDLE;
                    cnt_q <= '0;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // no padding, source and destination step together
    assign read_offset = cnt_q;
    assign write_offset = cnt_q;
    assign write_en = state_q == ST_WRITE;
    assign write_last = write_en && at_last;
    assign ready = state_q == ST_IDLE;
    assign done = state_q == ST_DONE;

    // idle only leaves for the write state on an allowed start
    no_write_in_idle_a: assert property (
        @(posedge clk) disable iff (!rst_b) (ready && !(start && allow)) |=> !write_en
    );

endmodule

// ==== hw/kv_write_client.sv ====
`timescale 1ns/1ns

module kv_write_client #(
    parameter int DATA_WIDTH = 512,
    parameter bit KV_WRITE_SWAP_DWORDS = 1'b1,
    localparam int OFFSET_W = $clog2(DATA_WIDTH / 32),
    localparam int DATA_NUM_DWORDS = DATA_WIDTH / 32
) (
    input logic clk,
    input logic rst_b,
    input logic zeroize,
    input logic [OFFSET_W:0] num_dwords,
    input kv_defines_pkg::kv_write_ctrl_reg_t write_ctrl_reg,
    // must be stable one cycle before dest_data_avail
    input kv_defines_pkg::kv_write_filter_metrics_t write_metrics,
    input logic dest_data_avail,
    input logic [DATA_NUM_DWORDS-1:0][31:0] dest_data,
    kv_write_if.client kv,
    output logic dest_keyvault,
    output kv_defines_pkg::kv_error_code_e error_code,
    output logic kv_ready,
    output logic dest_done
);

    logic write_allow;
    logic start;
    logic [OFFSET_W-1:0] read_offset;
    logic [OFFSET_W-1:0] write_offset;
    logic [OFFSET_W-1:0] sel_offset;
    logic write_en;
    logic write_last;

    kv_write_rule_check u_rule_check (
        .clk(clk),
        .rst_b(rst_b),
        .write_metrics(write_metrics),
        .write_allow(write_allow)
    );

    // strobes arriving mid-write are dropped here
    assign start = dest_data_avail && write_ctrl_reg.write_en && kv_ready;

    kv_fsm #(
        .DATA_WIDTH(DATA_WIDTH)
    ) u_fsm (
        .clk(clk),
        .rst_b(rst_b),
        .zeroize(zeroize),
        .start(start),
        .allow(write_allow),
        .num_dwords(num_dwords),
        .read_offset(read_offset),
        .write_en(write_en),
        .write_offset(write_offset),
        .write_last(write_last),
        .ready(kv_ready),
        .done(dest_done)
    );

    assign dest_keyvault = write_ctrl_reg.write_en;

    // swapped mode walks the result from its top dword down
    assign sel_offset = KV_WRITE_SWAP_DWORDS ? OFFSET_W'(DATA_NUM_DWORDS - 1) - read_offset
                                             : read_offset;

    assign kv.write_en = write_en;
    assign kv.write_entry = write_ctrl_reg.write_entry;
    assign kv.write_offset = kv_defines_pkg::kv_offset_t'(write_offset);
    assign kv.write_data = dest_data[sel_offset];
    // entry stays unusable until its last dword is in
    assign kv.write_dest_valid = write_last ? write_ctrl_reg.write_dest_vld : '0;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            error_code <= kv_defines_pkg::KV_SUCCESS;
        end else if (zeroize) begin
            error_code <= kv_defines_pkg::KV_SUCCESS;
        end else if (start && !write_allow) begin
            // refused by the rules, no dwords go out
            error_code <= kv_defines_pkg::KV_WRITE_FAIL;
        end else if (write_en) begin
            // each dword response overwrites, the final one sticks
            error_code <= kv.error ? kv_defines_pkg::KV_WRITE_FAIL : kv_defines_pkg::KV_SUCCESS;
        end
    end

    // the client is told done right after the closing dword
    last_then_done_a: assert property (
        @(posedge clk) disable iff (!rst_b || zeroize) write_last |=> dest_done
    );

endmodule

// ==== hw/kv_store.sv ====
`timescale 1ns/1ns

module kv_store (
    input logic clk,
    input logic rst_b,
    input logic zeroize,
    kv_write_if.vault kv,
    input logic lock_en,
    input logic [kv_defines_pkg::KV_ENTRY_ADDR_W-1:0] lock_entry,
    input logic [kv_defines_pkg::KV_ENTRY_ADDR_W-1:0] rd_entry,
    input kv_defines_pkg::kv_offset_t rd_offset,
    output logic [31:0] rd_data,
    output logic [kv_defines_pkg::KV_NUM_DEST-1:0] rd_dest_valid
);

    // entry, dword, bit
    logic [kv_defines_pkg::KV_NUM_ENTRIES-1:0][kv_defines_pkg::KV_ENTRY_DWORDS-1:0][31:0] data_q;
    logic [kv_defines_pkg::KV_NUM_ENTRIES-1:0][kv_defines_pkg::KV_NUM_DEST-1:0] dest_q;
    logic [kv_defines_pkg::KV_NUM_ENTRIES-1:0] lock_q;
    logic wr_accept;

    // locked entry rejects in the same cycle
    assign kv.error = lock_q[kv.write_entry];
    assign wr_accept = kv.write_en && !lock_q[kv.write_entry];

    // key material never survives reset or zeroize
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            data_q <= '0;
            dest_q <= '0;
        end else if (zeroize) begin
            // whole vault in one cycle
            data_q <= '0;
            dest_q <= '0;
        end else if (wr_accept) begin
            data_q[kv.write_entry][kv.write_offset] <= kv.write_data;
            // flags are zero until the last dword, then take the final set
            dest_q[kv.write_entry] <= kv.write_dest_valid;
        end
    end

    // locks are sticky, only reset releases them
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lock_q <= '0;
        end else if (lock_en) begin
            lock_q[lock_entry] <= 1'b1;
        end
    end

    // debug read port
    assign rd_data = data_q[rd_entry][rd_offset];
    assign rd_dest_valid = dest_q[rd_entry];

    // a write racing zeroize must not leave anything behind
    zeroize_clears_a: assert property (
        @(posedge clk) disable iff (!rst_b) zeroize |=> (data_q == '0) && (dest_q == '0)
    );

endmodule

// ==== hw/kv_write_subsys.sv ====
`timescale 1ns/1ns

module kv_write_subsys (
    input logic clk,
    input logic rst_b,
    input logic zeroize,
    input logic [kv_defines_pkg::KV_ENTRY_SIZE_W:0] num_dwords,
    input kv_defines_pkg::kv_write_ctrl_reg_t write_ctrl_reg,
    input kv_defines_pkg::kv_write_filter_metrics_t write_metrics,
    input logic dest_data_avail,
    input logic [kv_defines_pkg::KV_ENTRY_DWORDS-1:0][31:0] dest_data,
    output logic dest_keyvault,
    output kv_defines_pkg::kv_error_code_e error_code,
    output logic kv_ready,
    output logic dest_done,
    input logic lock_en,
    input logic [kv_defines_pkg::KV_ENTRY_ADDR_W-1:0] lock_entry,
    input logic [kv_defines_pkg::KV_ENTRY_ADDR_W-1:0] rd_entry,
    input kv_defines_pkg::kv_offset_t rd_offset,
    output logic [31:0] rd_data,
    output logic [kv_defines_pkg::KV_NUM_DEST-1:0] rd_dest_valid
);

    // client to vault write path
    kv_write_if kv_wr ();

    // client result fills a whole entry, stored dword swapped
    kv_write_client #(
        .DATA_WIDTH(kv_defines_pkg::KV_DATA_WIDTH),
        .KV_WRITE_SWAP_DWORDS(1'b1)
    ) u_write_client (
        .clk(clk),
        .rst_b(rst_b),
        .zeroize(zeroize),
        .num_dwords(num_dwords),
        .write_ctrl_reg(write_ctrl_reg),
        .write_metrics(write_metrics),
        .dest_data_avail(dest_data_avail),
        .dest_data(dest_data),
        .kv(kv_wr.client),
        .dest_keyvault(dest_keyvault),
        .error_code(error_code),
        .kv_ready(kv_ready),
        .dest_done(dest_done)
    );

    kv_store u_store (
        .clk(clk),
        .rst_b(rst_b),
        .zeroize(zeroize),
        .kv(kv_wr.vault),
        .lock_en(lock_en),
        .lock_entry(lock_entry),
        .rd_entry(rd_entry),
        .rd_offset(rd_offset),
        .rd_data(rd_data),
        .rd_dest_valid(rd_dest_valid)
    );

endmodule

// ==== test/kv_write_tb.sv ====
`timescale 1ns/1ns

module kv_write_tb;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_WRITES = 180;
    // a write takes at most 20 cycles, budget is 200 of them after reset
    localparam int CYCLE_LIMIT = RESET_CYCLES + 200 * 20;

    logic clk;
    logic rst_b;
    logic zeroize;
    logic [kv_defines_pkg::KV_ENTRY_SIZE_W:0] num_dwords;
    kv_defines_pkg::kv_write_ctrl_reg_t write_ctrl_reg;
    kv_defines_pkg::kv_write_filter_metrics_t write_metrics;
    logic dest_data_avail;
    logic [kv_defines_pkg::KV_ENTRY_DWORDS-1:0][31:0] dest_data;
    logic dest_keyvault;
    kv_defines_pkg::kv_error_code_e error_code;
    logic kv_ready;
    logic dest_done;
    logic lock_en;
    logic [kv_defines_pkg::KV_ENTRY_ADDR_W-1:0] lock_entry;
    logic [kv_defines_pkg::KV_ENTRY_ADDR_W-1:0] rd_entry;
    kv_defines_pkg::kv_offset_t rd_offset;
    logic [31:0] rd_data;
    logic [kv_defines_pkg::KV_NUM_DEST-1:0] rd_dest_valid;

    // vault model, entry by dword
    logic [31:0] model_data [kv_defines_pkg::KV_NUM_ENTRIES][kv_defines_pkg::KV_ENTRY_DWORDS];
    logic [kv_defines_pkg::KV_NUM_DEST-1:0] model_dest [kv_defines_pkg::KV_NUM_ENTRIES];
    logic model_lock [kv_defines_pkg::KV_NUM_ENTRIES];

    integer seed;
    int cycle_cnt = 0;

    kv_write_subsys u_kv_write_subsys (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    // runaway guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d clock cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    task automatic check_error(input kv_defines_pkg::kv_error_code_e got,
                               input kv_defines_pkg::kv_error_code_e exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s error_code %0h, expected %0h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_data(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s read %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_dest(input logic [kv_defines_pkg::KV_NUM_DEST-1:0] got,
                              input logic [kv_defines_pkg::KV_NUM_DEST-1:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s read %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // debug port is combinational, all dwords are read inside one low phase
    task automatic check_entry(input int entry);
        rd_entry = entry[kv_defines_pkg::KV_ENTRY_ADDR_W-1:0];
        for (int i = 0; i < kv_defines_pkg::KV_ENTRY_DWORDS; i++) begin
            rd_offset = i[kv_defines_pkg::KV_ENTRY_SIZE_W-1:0];
            #1;
            check_data(rd_data, model_data[entry][i], $sformatf("entry %0d dword %0d", entry, i));
        end
        check_dest(rd_dest_valid, model_dest[entry], $sformatf("entry %0d dest flags", entry));
    endtask

    task automatic set_lock(input logic [kv_defines_pkg::KV_ENTRY_ADDR_W-1:0] entry);
        @(negedge clk);
        lock_en = 1'b1;
        lock_entry = entry;
        @(negedge clk);
        lock_en = 1'b0;
        model_lock[entry] = 1'b1;
    endtask

    task automatic zeroize_vault();
        @(negedge clk);
        zeroize = 1'b1;
        @(negedge clk);
        zeroize = 1'b0;
        // data and flags go, locks stay
        for (int e = 0; e < kv_defines_pkg::KV_NUM_ENTRIES; e++) begin
            model_dest[e] = '0;
            for (int i = 0; i < kv_defines_pkg::KV_ENTRY_DWORDS; i++) begin
                model_data[e][i] = '0;
            end
        end
        check_error(error_code, kv_defines_pkg::KV_SUCCESS, "after zeroize");
        for (int e = 0; e < kv_defines_pkg::KV_NUM_ENTRIES; e++) begin
            // one entry per low phase
            @(negedge clk);
            check_entry(e);
        end
    endtask

    task automatic run_write(input logic [kv_defines_pkg::KV_ENTRY_ADDR_W-1:0] entry,
                             input logic [kv_defines_pkg::KV_CLIENT_ID_W-1:0] client_id,
                             input logic dbg_locked,
                             input logic [kv_defines_pkg::KV_ENTRY_SIZE_W:0] n,
                             input logic extra_strobe);
        logic [31:0] r;
        logic [kv_defines_pkg::KV_NUM_DEST-1:0] dest_vld;
        logic rule_ok;
        logic stored;
        kv_defines_pkg::kv_error_code_e exp_err;
        int k;
        // cycle t-1, metrics settle one cycle ahead of the strobe
        @(negedge clk);
        r = next_rand();
        dest_vld = r[kv_defines_pkg::KV_NUM_DEST-1:0];
        for (int i = 0; i < kv_defines_pkg::KV_ENTRY_DWORDS; i++) begin
            dest_data[i] = next_rand();
        end
        write_metrics.client_id = client_id;
        write_metrics.write_entry = entry;
        write_metrics.debug_locked = dbg_locked;
        write_ctrl_reg.write_en = 1'b1;
        write_ctrl_reg.write_entry = entry;
        write_ctrl_reg.write_dest_vld = dest_vld;
        num_dwords = n;
        rd_entry = entry;
        rd_offset = '0;
        // debug lock refuses all, reserved entries take the owner only
        rule_ok = !dbg_locked && (entry >= kv_defines_pkg::KV_RSVD_ENTRIES
                                  || client_id == kv_defines_pkg::KV_OWNER_ID);
        stored = rule_ok && !model_lock[entry];
        @(negedge clk);
        if (kv_ready !== 1'b1) begin
            $display("kv_ready was low when a write was about to start at %0t ns", $time);
            abort_run();
        end
        // vault is the destination whenever the control register enables a write
        check_flag(dest_keyvault, 1'b1, "dest_keyvault with write_en set");
        dest_data_avail = 1'b1;
        // cycle t+1, busy, so a second strobe here must be dropped
        @(negedge clk);
        dest_data_avail = extra_strobe;
        if (kv_ready !== 1'b0) begin
            $display("kv_ready stayed high after the start strobe at %0t ns", $time);
            abort_run();
        end
        k = 1;
        while (dest_done !== 1'b1) begin
            // k-1 dwords are in, flags held clear until the last one
            if (stored && k >= 2) begin
                check_dest(rd_dest_valid, '0, "dest flags during write");
            end
            @(negedge clk);
            dest_data_avail = 1'b0;
            k++;
        end
        if (k != (rule_ok ? int'(n) + 1 : 1)) begin
            $display("dest_done came %0d cycles after the strobe, expected %0d",
                     k, rule_ok ? int'(n) + 1 : 1);
            abort_run();
        end
        if (stored) begin
            // swapped, top dword of the result lands at offset 0
            for (int i = 0; i < int'(n); i++) begin
                model_data[entry][i] = dest_data[kv_defines_pkg::KV_ENTRY_DWORDS - 1 - i];
            end
            model_dest[entry] = dest_vld;
            exp_err = kv_defines_pkg::KV_SUCCESS;
        end else begin
            exp_err = kv_defines_pkg::KV_WRITE_FAIL;
        end
        check_error(error_code, exp_err, $sformatf("write to entry %0d", entry));
        check_entry(int'(entry));
        @(negedge clk);
        dest_data_avail = 1'b0;
        // single done pulse and no second write
        if (kv_ready !== 1'b1 || dest_done !== 1'b0) begin
            $display("client not idle the cycle after dest_done at %0t ns", $time);
            abort_run();
        end
    endtask

    initial begin
        logic [31:0] r;
        seed = 48120;
        rst_b = 1'b0;
        zeroize = 1'b0;
        num_dwords = '0;
        write_ctrl_reg = '0;
        write_metrics = '0;
        dest_data_avail = 1'b0;
        dest_data = '0;
        lock_en = 1'b0;
        lock_entry = '0;
        rd_entry = '0;
        rd_offset = '0;
        for (int e = 0; e < kv_defines_pkg::KV_NUM_ENTRIES; e++) begin
            model_dest[e] = '0;
            model_lock[e] = 1'b0;
            for (int i = 0; i < kv_defines_pkg::KV_ENTRY_DWORDS; i++) begin
                model_data[e][i] = '0;
            end
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_b = 1'b1;
        check_error(error_code, kv_defines_pkg::KV_SUCCESS, "after reset");
        check_flag(dest_keyvault, 1'b0, "dest_keyvault with write_en clear");
        for (int w = 0; w < NUM_WRITES; w++) begin
            if (w == 60) begin
                set_lock(3'd6);
            end
            if (w == 120) begin
                set_lock(3'd3);
            end
            if (w == 90 || w == 150) begin
                // leave a failed code behind for zeroize to clear
                run_write(3'd4, 3'd0, 1'b1, 5'd4, 1'b0);
                zeroize_vault();
                // entry 6 must still be locked
                run_write(3'd6, 3'd0, 1'b0, 5'd16, 1'b0);
            end
            r = next_rand();
            run_write(r[2:0], r[3] ? r[6:4] : kv_defines_pkg::KV_OWNER_ID, r[9:7] == 3'd0,
                      {1'b0, r[13:10]} + 5'd1, r[14]);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== sources.f ====
hw/kv_defines_pkg.sv
hw/kv_write_if.sv
hw/kv_write_rule_check.sv
hw/kv_fsm.sv
hw/kv_write_client.sv
hw/kv_store.sv
hw/kv_write_subsys.sv
test/kv_write_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the key vault write testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module kv_write_tb \
    -f sources.f -o kv_write_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/kv_write_tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
